//--- source/mips_config.svh
// mips core configuration: reset vector, word width and register count
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// first fetch address after reset (kseg1 boot rom)
`define RESET_VECTOR 32'hBFC00000

// width of registers, the alu and both data buses
`define DATA_WIDTH 32

// number of general purpose registers, $zero included
`define REG_COUNT 32

// register numbers brought out as debug taps
`define REG_V0 2
`define REG_V3 3

`endif

//--- source/mips_pkg.sv
// mips core package: opcode and funct encodings, instruction views, control word
package mips_pkg;

  typedef enum logic [5:0] {
    op_special = 6'h00, // r-type, decoded further by funct
    op_j       = 6'h02,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_ori     = 6'h0d,
    op_lui     = 6'h0f,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_t;

  typedef enum logic [5:0] {
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_slt  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    alu_add    = 3'd0,
    alu_sub    = 3'd1,
    alu_and    = 3'd2,
    alu_or     = 3'd3,
    alu_slt    = 3'd4,
    alu_pass_b = 3'd5 // lui, immediate already shifted
  } alu_op_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    funct_t      funct;
  } r_format_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_format_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] target;
  } j_format_t;

  // one fetched word, read through whichever format the opcode implies
  typedef union packed {
    r_format_t r;
    i_format_t i;
    j_format_t j;
  } instruction_t;

  typedef struct packed {
    logic    reg_write;
    logic    dest_rd;      // write rd instead of rt
    logic    alu_src_imm;
    logic    imm_zero_ext;
    logic    imm_upper;    // lui
    alu_op_t alu_op;
    logic    mem_read;
    logic    mem_write;
    logic    branch_eq;
    logic    branch_ne;
    logic    jump;
  } control_t;

endpackage

//--- source/register_file.sv
// register file: two combinational read ports, one clocked write port, debug taps
`timescale 1ns/1ps
`include "mips_config.svh"

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   write_enable,
  input  logic [4:0]             read_addr_a,
  input  logic [4:0]             read_addr_b,
  input  logic [4:0]             write_addr,
  input  logic [`DATA_WIDTH-1:0] write_data,
  output logic [`DATA_WIDTH-1:0] read_data_a,
  output logic [`DATA_WIDTH-1:0] read_data_b,
  output logic [`DATA_WIDTH-1:0] reg_v0,
  output logic [`DATA_WIDTH-1:0] reg_v3
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_addr != 5'd0) begin // $zero is never written
      regs[write_addr] <= write_data;
    end
  end

  // $zero reads back as zero on both ports
  assign read_data_a = (read_addr_a == 5'd0) ? '0 : regs[read_addr_a];
  assign read_data_b = (read_addr_b == 5'd0) ? '0 : regs[read_addr_b];

  // debug taps
  assign reg_v0 = regs[`REG_V0];
  assign reg_v3 = regs[`REG_V3];

endmodule

//--- source/program_counter.sv
// program counter: reset vector load and next pc selection for branch and jump
`timescale 1ns/1ps
`include "mips_config.svh"

module program_counter import mips_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   run,
  input  control_t               control,
  input  instruction_t           instr,
  input  logic                   zero,
  output logic [`DATA_WIDTH-1:0] pc
);

  logic [`DATA_WIDTH-1:0] pc_plus4;
  logic [`DATA_WIDTH-1:0] branch_offset;
  logic [`DATA_WIDTH-1:0] branch_target;
  logic [`DATA_WIDTH-1:0] jump_target;
  logic [`DATA_WIDTH-1:0] next_pc;
  logic                   take_branch;

  assign pc_plus4 = pc + `DATA_WIDTH'd4;

  // sign extended word offset, shifted left 2
  assign branch_offset = {{(`DATA_WIDTH-18){instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign branch_target = pc_plus4 + branch_offset;

  // region of pc+4, 26-bit word index, byte alignment
  assign jump_target = {pc_plus4[31:28], instr.j.target, 2'b00};

  assign take_branch = (control.branch_eq && zero) || (control.branch_ne && !zero);

  // no delay slot, a taken branch redirects the very next fetch
  always_comb begin
    if (control.jump) begin
      next_pc = jump_target;
    end else if (take_branch) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_VECTOR;
    end else if (run) begin // run low holds the fetch address
      pc <= next_pc;
    end
  end

endmodule

//--- source/instruction_decoder.sv
// instruction decoder: maps opcode and funct onto the control word
`timescale 1ns/1ps

module instruction_decoder import mips_pkg::*; (
  input  instruction_t instr,
  output control_t     control
);

  always_comb begin
    control = '0; // anything not listed below is a no-op

    case (instr.r.opcode)
      op_special: begin
        control.reg_write = 1'b1;
        control.dest_rd   = 1'b1;
        case (instr.r.funct)
          fn_addu: control.alu_op = alu_add;
          fn_subu: control.alu_op = alu_sub;
          fn_and:  control.alu_op = alu_and;
          fn_or:   control.alu_op = alu_or;
          fn_slt:  control.alu_op = alu_slt;
          default: control = '0; // includes sll $0,$0,0, the canonical nop
        endcase
      end
      op_addiu: begin
        control.reg_write   = 1'b1;
        control.alu_src_imm = 1'b1;
        control.alu_op      = alu_add;
      end
      op_ori: begin
        control.reg_write    = 1'b1;
        control.alu_src_imm  = 1'b1;
        control.imm_zero_ext = 1'b1;
        control.alu_op       = alu_or;
      end
      op_lui: begin
        control.reg_write   = 1'b1;
        control.alu_src_imm = 1'b1;
        control.imm_upper   = 1'b1;
        control.alu_op      = alu_pass_b;
      end
      op_lw: begin
        control.reg_write   = 1'b1;
        control.alu_src_imm = 1'b1;
        control.alu_op      = alu_add; // base + offset
        control.mem_read    = 1'b1;
      end
      op_sw: begin
        control.alu_src_imm = 1'b1;
        control.alu_op      = alu_add;
        control.mem_write   = 1'b1;
      end
      op_beq:  control.branch_eq = 1'b1;
      op_bne:  control.branch_ne = 1'b1;
      op_j:    control.jump = 1'b1;
      default: control = '0;
    endcase
  end

endmodule

//--- source/execute_unit.sv
// execute unit: immediate forming, alu, equality compare and write-back select
`timescale 1ns/1ps
`include "mips_config.svh"

module execute_unit import mips_pkg::*; (
  input  instruction_t           instr,
  input  control_t               control,
  input  logic [`DATA_WIDTH-1:0] operand_a,
  input  logic [`DATA_WIDTH-1:0] operand_b,
  input  logic [`DATA_WIDTH-1:0] load_data,
  output logic [`DATA_WIDTH-1:0] result,
  output logic [`DATA_WIDTH-1:0] data_addr,
  output logic                   zero
);

  logic [`DATA_WIDTH-1:0] imm;
  logic [`DATA_WIDTH-1:0] alu_b;
  logic [`DATA_WIDTH-1:0] alu_out;

  always_comb begin
    if (control.imm_upper) begin
      imm = {instr.i.imm, {(`DATA_WIDTH-16){1'b0}}}; // lui, shift left 16
    end else if (control.imm_zero_ext) begin
      imm = {{(`DATA_WIDTH-16){1'b0}}, instr.i.imm};
    end else begin
      imm = {{(`DATA_WIDTH-16){instr.i.imm[15]}}, instr.i.imm};
    end
  end

  assign alu_b = control.alu_src_imm ? imm : operand_b;

  // addu/subu wrap silently, no overflow trap
  always_comb begin
    case (control.alu_op)
      alu_add:    alu_out = operand_a + alu_b;
      alu_sub:    alu_out = operand_a - alu_b;
      alu_and:    alu_out = operand_a & alu_b;
      alu_or:     alu_out = operand_a | alu_b;
      alu_slt:    alu_out = {{(`DATA_WIDTH-1){1'b0}}, $signed(operand_a) < $signed(alu_b)};
      alu_pass_b: alu_out = alu_b;
      default:    alu_out = '0;
    endcase
  end

  // branch compare works on the raw register values
  assign zero = (operand_a == operand_b);

  assign data_addr = alu_out; // effective address for lw and sw
  assign result    = control.mem_read ? load_data : alu_out;

endmodule

//--- source/mips_core.sv
// single-cycle mips32 subset core with big-endian to little-endian data swap
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_core import mips_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   run,
  input  logic [`DATA_WIDTH-1:0] instr_data,
  input  logic [`DATA_WIDTH-1:0] data_rdata,
  output logic [`DATA_WIDTH-1:0] instr_addr,
  output logic [`DATA_WIDTH-1:0] data_addr,
  output logic [`DATA_WIDTH-1:0] data_wdata,
  output logic                   data_write,
  output logic [`DATA_WIDTH-1:0] reg_v0,
  output logic [`DATA_WIDTH-1:0] reg_v3
);

  instruction_t           instr;
  control_t               control;
  logic [`DATA_WIDTH-1:0] read_data_a;
  logic [`DATA_WIDTH-1:0] read_data_b;
  logic [`DATA_WIDTH-1:0] load_data;
  logic [`DATA_WIDTH-1:0] write_back;
  logic [4:0]             write_addr;
  logic                   reg_write_en;
  logic                   zero;

  // memory holds words little-endian, the core works big-endian
  function automatic logic [31:0] byte_swap(input logic [31:0] word);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  assign instr = instr_data;

  assign write_addr   = control.dest_rd ? instr.r.rd : instr.r.rt;
  assign reg_write_en = control.reg_write & run; // stalled cycles leave state alone
  assign data_write   = control.mem_write & run;

  assign data_wdata = byte_swap(read_data_b); // sw stores rt
  assign load_data  = byte_swap(data_rdata);

  register_file u_register_file (
    .clk          (clk),
    .reset        (reset),
    .write_enable (reg_write_en),
    .read_addr_a  (instr.r.rs),
    .read_addr_b  (instr.r.rt),
    .write_addr   (write_addr),
    .write_data   (write_back),
    .read_data_a  (read_data_a),
    .read_data_b  (read_data_b),
    .reg_v0       (reg_v0),
    .reg_v3       (reg_v3)
  );

  program_counter u_program_counter (
    .clk     (clk),
    .reset   (reset),
    .run     (run),
    .control (control),
    .instr   (instr),
    .zero    (zero),
    .pc      (instr_addr)
  );

  instruction_decoder u_instruction_decoder (
    .instr   (instr),
    .control (control)
  );

  execute_unit u_execute_unit (
    .instr     (instr),
    .control   (control),
    .operand_a (read_data_a),
    .operand_b (read_data_b),
    .load_data (load_data),
    .result    (write_back),
    .data_addr (data_addr),
    .zero      (zero)
  );

endmodule

//--- verification/mips_core_checker.sv
// bus checker for the mips core: store strobe gating and fetch address rules
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_core_checker (
  input logic                   clk,
  input logic                   reset,
  input logic                   run,
  input logic                   data_write,
  input logic [`DATA_WIDTH-1:0] instr_addr
);

  // a frozen or resetting core never strobes a store
  no_store_when_idle: assert property (@(posedge clk) (reset || !run) |-> !data_write)
    else $error("data_write high during reset or with run low");

  fetch_aligned: assert property (
    @(posedge clk) disable iff (reset) instr_addr[1:0] == 2'b00)
    else $error("instr_addr %h is not word aligned", instr_addr);

  pc_frozen: assert property (@(posedge clk) disable iff (reset) !run |=> $stable(instr_addr))
    else $error("instr_addr moved while run was low");

  // first fetch after reset comes from the boot vector
  boot_fetch: assert property (@(posedge clk) $fell(reset) |-> instr_addr == `RESET_VECTOR)
    else $error("instr_addr %h after reset", instr_addr);

endmodule

bind mips_core mips_core_checker u_checker (
  .clk        (clk),
  .reset      (reset),
  .run        (run),
  .data_write (data_write),
  .instr_addr (instr_addr)
);

//--- verification/mips_core_tb.sv
// testbench for the mips core with memory models, directed programs and a closing report
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_core_tb import mips_pkg::*; ();

  localparam logic [31:0] done_addr = 32'h0000_00f0; // marker store that ends a program
  localparam logic [4:0]  v0 = 5'd2, v3 = 5'd3, t0 = 5'd8, t1 = 5'd9;

  logic        clk, reset, run, data_write;
  logic [31:0] instr_data, data_rdata, instr_addr, data_addr, data_wdata, reg_v0, reg_v3;
  logic [31:0] imem [64]; // word index counted from the reset vector
  logic [31:0] dmem [64]; // little-endian words from byte address 0
  logic [31:0] fetch_offset;
  logic [31:0] store_addr [$];
  logic [31:0] store_data [$];
  logic [5:0]  prog_len;
  int          first_store, errors, checks;
  integer      seed;

  mips_core DUT (.*);

  always #10 clk = ~clk;

  assign fetch_offset = instr_addr - `RESET_VECTOR;
  assign instr_data   = imem[fetch_offset[7:2]];
  assign data_rdata   = dmem[data_addr[7:2]];

  // stores are logged half a cycle before they commit
  always @(negedge clk) begin
    if (!reset && run && data_write) begin
      store_addr.push_back(data_addr);
      store_data.push_back(data_wdata);
    end
  end

  function automatic logic [31:0] rtype(funct_t fn, logic [4:0] rs, rt, rd);
    return {op_special, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] itype(opcode_t op, logic [4:0] rs, rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jtype(logic [5:0] index); // absolute jump to a word index
    logic [31:0] target;
    target = `RESET_VECTOR + {24'd0, index, 2'b00};
    return {op_j, target[27:2]};
  endfunction

  task automatic emit(logic [31:0] word);
    imem[prog_len] = word;
    prog_len = prog_len + 6'd1;
  endtask

  task automatic start_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'h0; // sll $0,$0,0
      dmem[i] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0403);
    end
    prog_len    = 6'd0;
    first_store = store_addr.size();
  endtask

  // marker store and a jump to itself, then reset with run low
  task automatic close_program();
    emit(itype(op_sw, 5'd0, 5'd0, done_addr[15:0]));
    emit(jtype(prog_len));
    @(posedge clk);
    reset <= 1'b1;
    run   <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  task automatic run_until_done(int limit);
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    @(posedge clk);
    run <= 1'b1;
    while (!done && cycles < limit) begin
      @(negedge clk);
      done = data_write && (data_addr == done_addr);
      cycles++;
    end
    @(posedge clk);
    run <= 1'b0; // marker store completes at this edge
    @(negedge clk);
    if (!done) begin
      $display("timeout: no marker store within %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      $display("error: %s got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic check_store(logic [31:0] addr, logic [31:0] value, bit present);
    logic [31:0] expected;
    bit          found;
    expected = {<<8{value}}; // memory sees the little-endian word
    found    = 1'b0;
    checks++;
    for (int k = first_store; k < store_addr.size(); k++) begin
      if (store_addr[k] == addr) begin
        found = 1'b1;
        if (store_data[k] !== expected) begin
          $display("error: data_wdata at %h got %h expected %h", addr, store_data[k], expected);
          errors++;
        end
      end
    end
    if (found != present) begin
      $display("store to address %h %s", addr, present ? "is missing" : "was not skipped");
      errors++;
    end
  endtask

  task automatic test_reset();
    start_program();
    close_program();
    check_value("instr_addr", instr_addr, `RESET_VECTOR);
    check_value("reg_v0", reg_v0, 32'h0);
    check_value("reg_v3", reg_v3, 32'h0);
    check_value("data_write", {31'd0, data_write}, 32'h0);
  endtask

  task automatic test_alu();
    funct_t      fns [5];
    logic [31:0] a, b, expected;
    logic [15:0] imm;
    fns = '{fn_addu, fn_subu, fn_and, fn_or, fn_slt};
    a   = $random(seed);
    b   = $random(seed);
    imm = 16'($random(seed));
    start_program();
    emit(itype(op_lui, 5'd0, v0, a[31:16]));
    emit(itype(op_ori, v0, v0, a[15:0])); // low half is zero extended
    emit(itype(op_lui, 5'd0, v3, b[31:16]));
    emit(itype(op_ori, v3, v3, b[15:0]));
    for (int k = 0; k < 5; k++) begin
      emit(rtype(fns[k], v0, v3, t0));
      emit(itype(op_sw, 5'd0, t0, 16'(4 * k)));
    end
    emit(itype(op_addiu, v0, t1, imm));
    emit(itype(op_sw, 5'd0, t1, 16'h0014));
    close_program();
    run_until_done(100);
    check_value("reg_v0", reg_v0, a);
    check_value("reg_v3", reg_v3, b);
    for (int k = 0; k < 5; k++) begin
      case (fns[k])
        fn_addu: expected = a + b;
        fn_subu: expected = a - b;
        fn_and:  expected = a & b;
        fn_or:   expected = a | b;
        default: expected = {31'd0, $signed(a) < $signed(b)};
      endcase
      check_store(32'(4 * k), expected, 1'b1);
    end
    check_store(32'h14, a + {{16{imm[15]}}, imm}, 1'b1);
  endtask

  task automatic test_memory();
    logic [31:0] word8, word9;
    start_program();
    word8 = {<<8{dmem[8]}}; // big-endian view of words 8 and 9
    word9 = {<<8{dmem[9]}};
    emit(itype(op_lw, 5'd0, v0, 16'h0020));
    emit(itype(op_addiu, 5'd0, t0, 16'h0020));
    emit(itype(op_lw, t0, v3, 16'h0004));
    emit(itype(op_sw, t0, v0, 16'h0028)); // lands at 0x48
    emit(itype(op_addiu, 5'd0, 5'd0, 16'h1234)); // $zero ignores the write
    emit(itype(op_sw, 5'd0, 5'd0, 16'h004c));
    close_program();
    run_until_done(100);
    check_value("reg_v0", reg_v0, word8);
    check_value("reg_v3", reg_v3, word9);
    check_store(32'h48, word8, 1'b1);
    check_store(32'h4c, 32'h0, 1'b1);
  endtask

  task automatic test_branches();
    start_program();
    emit(itype(op_addiu, 5'd0, t0, 16'h0001));
    emit(itype(op_addiu, 5'd0, t1, 16'h0001));
    emit(itype(op_beq, t0, t1, 16'h0001)); // taken
    emit(itype(op_sw, 5'd0, 5'd0, 16'h0040));
    emit(itype(op_bne, t0, t1, 16'h0001)); // falls through
    emit(itype(op_sw, 5'd0, 5'd0, 16'h0044));
    emit(itype(op_beq, t0, 5'd0, 16'h0001)); // falls through
    emit(itype(op_sw, 5'd0, 5'd0, 16'h0048));
    emit(itype(op_bne, t0, 5'd0, 16'h0001)); // taken
    emit(itype(op_sw, 5'd0, 5'd0, 16'h004c));
    emit(jtype(6'd12));
    emit(itype(op_sw, 5'd0, 5'd0, 16'h0050));
    emit(itype(op_sw, 5'd0, 5'd0, 16'h0054)); // jump target at word 12
    close_program();
    run_until_done(100);
    check_store(32'h40, 32'h0, 1'b0);
    check_store(32'h44, 32'h0, 1'b1);
    check_store(32'h48, 32'h0, 1'b1);
    check_store(32'h4c, 32'h0, 1'b0);
    check_store(32'h50, 32'h0, 1'b0);
    check_store(32'h54, 32'h0, 1'b1);
  endtask

  task automatic test_stall();
    logic [31:0] held_v0 [2];
    held_v0 = '{32'h77, 32'h77 + 32'h11};
    start_program();
    emit(itype(op_addiu, 5'd0, v0, 16'h0077));
    emit(itype(op_addiu, v0, v0, 16'h0011)); // first stall would bump v0
    emit(itype(op_sw, 5'd0, v0, 16'h0030)); // second stall holds the store
    close_program();
    for (int s = 0; s < 2; s++) begin
      @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0; // exactly one instruction completes here
      for (int i = 0; i < 5; i++) begin
        @(negedge clk);
        check_value("instr_addr", instr_addr, `RESET_VECTOR + 32'(4 * (s + 1)));
        check_value("reg_v0", reg_v0, held_v0[s]);
        check_value("data_write", {31'd0, data_write}, 32'h0);
      end
    end
    run_until_done(100);
    check_store(32'h30, 32'h77 + 32'h11, 1'b1);
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  initial begin
    clk    = 1'b0;
    reset <= 1'b1;
    run   <= 1'b0;
    errors = 0;
    checks = 0;
    seed   = 34961;
    test_reset();
    test_alu();
    test_memory();
    test_reset(); // registers still hold data from earlier programs
    test_branches();
    test_stall();
    finish_run();
  end

endmodule

//--- list.f
+incdir+source
source/mips_pkg.sv
source/register_file.sv
source/program_counter.sv
source/instruction_decoder.sv
source/execute_unit.sv
source/mips_core.sv
verification/mips_core_checker.sv
verification/mips_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the mips core testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mips_core_tb -f list.f
output=$(./obj_dir/Vmips_core_tb 2>&1) || true
echo "$output"
echo "$output" | grep -qx "Finished with no errors"
